// ==== logic/fsq_pkg.sv ====
`default_nettype none

package fsq_pkg;

    // virtual address width
    localparam int vaddr_w = 32;

    // most instructions in one fetch block
    localparam int block_inst = 8;
    localparam int size_w = $clog2(block_inst);

    // backend retire width
    localparam int commit_w = 4;
    localparam int commit_num_w = $clog2(commit_w + 1);

    // one queue slot, size is instruction count minus one
    typedef struct packed {
        logic [vaddr_w-1:0] start_addr;
        logic [size_w-1:0]  size;
        logic [vaddr_w-1:0] target;
        logic               taken;
    } fetch_stream_t;

    // backend writeback record
    typedef struct packed {
        logic               mispred;
        logic [size_w-1:0]  offset;
        logic [vaddr_w-1:0] target;
        logic               taken;
    } wb_info_t;

endpackage

`default_nettype wire

// ==== logic/fsq_redirect_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface fsq_redirect_if #(
    parameter int depth = 8
);
    import fsq_pkg::*;

    localparam int ptr_w = $clog2(depth) + 1;

    logic               en;
    logic [ptr_w-1:0]   ptr;
    logic [size_w-1:0]  offset;
    logic [vaddr_w-1:0] target;
    logic               taken;

    // record as stored for the redirected stream
    wb_info_t rec;

    assign rec = '{mispred: 1'b1, offset: offset, target: target, taken: taken};

    modport enq (input en, input ptr);
    modport issue (input en, input ptr);
    modport wb (input en, input ptr, input rec);

endinterface

`default_nettype wire

// ==== logic/fsq_store.sv ====
`timescale 1ns/100ps
`default_nettype none

module fsq_store #(
    parameter int  depth      = 8,
    parameter int  read_ports = 1,
    parameter type payload_t  = logic
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] waddr,
    input  payload_t                 wdata,
    input  logic [$clog2(depth)-1:0] raddr [read_ports],
    output payload_t                 rdata [read_ports]
);

    payload_t mem [depth];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem <= '{default: '0};
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // combinational read, new data visible the cycle after the write
    for (genvar i = 0; i < read_ports; i++) begin : g_read
        assign rdata[i] = mem[raddr[i]];
    end

    a_waddr_valid: assert property (
        @(posedge clk) disable iff (rst)
        we |-> !$isunknown(waddr) && (waddr < depth)
    );

endmodule

`default_nettype wire

// ==== logic/fsq_enqueue.sv ====
`timescale 1ns/100ps
`default_nettype none

module fsq_enqueue #(
    parameter int depth = 8
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     pred_en,
    input  fsq_pkg::fetch_stream_t   pred_stream,
    fsq_redirect_if.enq              redirect,
    input  logic [$clog2(depth):0]   commit_ptr,
    output logic [$clog2(depth):0]   tail_ptr,
    output logic                     full,
    output logic                     store_we,
    output logic [$clog2(depth)-1:0] store_waddr,
    output fsq_pkg::fetch_stream_t   store_wdata
);

    localparam int idx_w = $clog2(depth);
    localparam int ptr_w = idx_w + 1;

    // same slot, one lap apart
    assign full = (tail_ptr[idx_w-1:0] == commit_ptr[idx_w-1:0])
               && (tail_ptr[idx_w] != commit_ptr[idx_w]);

    // predictor write is dropped while the backend redirects
    assign store_we = pred_en && !full && !redirect.en;
    assign store_waddr = tail_ptr[idx_w-1:0];
    assign store_wdata = pred_stream;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tail_ptr <= '0;
        end else if (redirect.en) begin
            // younger streams are gone
            tail_ptr <= redirect.ptr + 1'b1;
        end else if (store_we) begin
            tail_ptr <= tail_ptr + 1'b1;
        end
    end

    // occupancy seen against the retire side
    a_occupancy: assert property (
        @(posedge clk) disable iff (rst)
        ptr_w'(tail_ptr - commit_ptr) <= depth
    );

endmodule

`default_nettype wire

// ==== logic/fsq_issue.sv ====
`timescale 1ns/100ps
`default_nettype none

module fsq_issue #(
    parameter int depth = 8
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [$clog2(depth):0]   tail_ptr,
    fsq_redirect_if.issue            redirect,
    output logic [$clog2(depth)-1:0] rd_ptr,
    input  fsq_pkg::fetch_stream_t   rd_stream,
    output logic                     cache_en,
    output logic [$clog2(depth):0]   cache_ptr,
    output fsq_pkg::fetch_stream_t   cache_stream,
    input  logic                     cache_ready
);

    localparam int idx_w = $clog2(depth);

    logic [idx_w:0] search_ptr;
    logic           pending;
    logic           load;
    logic           take;

    assign rd_ptr = search_ptr[idx_w-1:0];

    // something written but not yet sent to the icache
    assign pending = (search_ptr != tail_ptr);

    // request slot is free or being consumed this cycle
    assign load = !redirect.en && (cache_ready || !cache_en);
    assign take = load && pending;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            search_ptr <= '0;
            cache_en <= 1'b0;
        end else if (redirect.en) begin
            search_ptr <= redirect.ptr + 1'b1;
            cache_en <= 1'b0;
        end else if (load) begin
            cache_en <= pending;
            if (pending) begin
                search_ptr <= search_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            cache_ptr <= search_ptr;
            cache_stream <= rd_stream;
        end
    end

    // icache sees a steady request under back-pressure
    a_stall_hold: assert property (
        @(posedge clk) disable iff (rst)
        cache_en && !cache_ready |=> $stable(cache_ptr) && $stable(cache_stream)
    );

endmodule

`default_nettype wire

// ==== logic/fsq_commit.sv ====
`timescale 1ns/100ps
`default_nettype none

module fsq_commit #(
    parameter int depth = 8
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [fsq_pkg::commit_num_w-1:0]  commit_num,
    fsq_redirect_if.wb                        redirect,
    input  logic                              enq_we,
    input  logic [$clog2(depth)-1:0]          enq_ptr,
    input  logic [fsq_pkg::size_w-1:0]        commit_size,
    output logic [$clog2(depth):0]            commit_ptr,
    output logic                              retire,
    output fsq_pkg::wb_info_t                 wb_info
);
    import fsq_pkg::*;

    localparam int idx_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth * block_inst) + 1;

    logic [cnt_w-1:0]  inst_cnt;
    logic [cnt_w:0]    cnt_next;
    logic [cnt_w:0]    consume;
    logic [size_w-1:0] eff_size;

    logic             wb_we;
    logic [idx_w-1:0] wb_waddr;
    wb_info_t         wb_wdata;
    logic [idx_w-1:0] wb_raddr [1];
    wb_info_t         wb_rdata [1];

    // redirect writes the record, a fresh enqueue wipes it
    assign wb_we = redirect.en || enq_we;
    assign wb_waddr = redirect.en ? redirect.ptr[idx_w-1:0] : enq_ptr;
    assign wb_wdata = redirect.en ? redirect.rec : '0;
    assign wb_raddr[0] = commit_ptr[idx_w-1:0];
    assign wb_info = wb_rdata[0];

    fsq_store #(
        .depth      (depth),
        .read_ports (1),
        .payload_t  (wb_info_t)
    ) wb_store_i (
        .clk   (clk),
        .rst   (rst),
        .we    (wb_we),
        .waddr (wb_waddr),
        .wdata (wb_wdata),
        .raddr (wb_raddr),
        .rdata (wb_rdata)
    );

    // mispredicted stream ends at the redirecting instruction
    assign eff_size = wb_info.mispred ? wb_info.offset : commit_size;

    assign retire = inst_cnt > cnt_w'(eff_size);
    assign consume = retire ? (cnt_w + 1)'(eff_size) + 1'b1 : '0;
    assign cnt_next = {1'b0, inst_cnt} + (cnt_w + 1)'(commit_num) - consume;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            inst_cnt <= '0;
            commit_ptr <= '0;
        end else begin
            inst_cnt <= cnt_next[cnt_w-1:0];
            if (retire) begin
                commit_ptr <= commit_ptr + 1'b1;
            end
        end
    end

    // backend never retires more than the queue holds
    a_cnt_range: assert property (
        @(posedge clk) disable iff (rst)
        !cnt_next[cnt_w]
    );

endmodule

`default_nettype wire

// ==== logic/fsq_update_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module fsq_update_gen #(
    parameter int depth = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   retire,
    input  logic [$clog2(depth):0] commit_ptr,
    input  fsq_pkg::fetch_stream_t commit_stream,
    input  fsq_pkg::wb_info_t      wb_info,
    output logic                   update_en,
    output logic [$clog2(depth):0] update_ptr,
    output fsq_pkg::fetch_stream_t update_stream,
    output logic                   update_mispred
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            update_en <= 1'b0;
        end else begin
            update_en <= retire;
        end
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            update_ptr <= commit_ptr;
            update_mispred <= wb_info.mispred;
            update_stream.start_addr <= commit_stream.start_addr;
            // backend outcome overrides the prediction
            if (wb_info.mispred) begin
                update_stream.size <= wb_info.offset;
                update_stream.target <= wb_info.target;
                update_stream.taken <= wb_info.taken;
            end else begin
                update_stream.size <= commit_stream.size;
                update_stream.target <= commit_stream.target;
                update_stream.taken <= commit_stream.taken;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/fsq_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module fsq_top #(
    parameter int depth = 8
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             pred_en,
    input  logic [fsq_pkg::vaddr_w-1:0]      pred_start_addr,
    input  logic [fsq_pkg::size_w-1:0]       pred_size,
    input  logic [fsq_pkg::vaddr_w-1:0]      pred_target,
    input  logic                             pred_taken,
    output logic                             full,
    output logic                             cache_en,
    output logic [$clog2(depth):0]           cache_ptr,
    output logic [fsq_pkg::vaddr_w-1:0]      cache_start_addr,
    output logic [fsq_pkg::size_w-1:0]       cache_size,
    output logic [fsq_pkg::vaddr_w-1:0]      cache_target,
    output logic                             cache_taken,
    input  logic                             cache_ready,
    input  logic                             redirect_en,
    input  logic [$clog2(depth):0]           redirect_ptr,
    input  logic [fsq_pkg::size_w-1:0]       redirect_offset,
    input  logic [fsq_pkg::vaddr_w-1:0]      redirect_target,
    input  logic                             redirect_taken,
    input  logic [fsq_pkg::commit_num_w-1:0] commit_num,
    output logic                             update_en,
    output logic [$clog2(depth):0]           update_ptr,
    output logic [fsq_pkg::vaddr_w-1:0]      update_start_addr,
    output logic [fsq_pkg::size_w-1:0]       update_size,
    output logic [fsq_pkg::vaddr_w-1:0]      update_target,
    output logic                             update_taken,
    output logic                             update_mispred
);
    import fsq_pkg::*;

    localparam int idx_w = $clog2(depth);

    fetch_stream_t    pred_stream;
    fetch_stream_t    cache_stream;
    fetch_stream_t    update_stream;
    fetch_stream_t    store_wdata;
    fetch_stream_t    store_rdata [2];
    logic [idx_w-1:0] store_raddr [2];
    logic [idx_w-1:0] store_waddr;
    logic [idx_w-1:0] rd_ptr;
    logic             store_we;
    logic [idx_w:0]   tail_ptr;
    logic [idx_w:0]   commit_ptr;
    logic             retire;
    wb_info_t         wb_info;

    fsq_redirect_if #(.depth(depth)) redirect_i ();

    assign redirect_i.en = redirect_en;
    assign redirect_i.ptr = redirect_ptr;
    assign redirect_i.offset = redirect_offset;
    assign redirect_i.target = redirect_target;
    assign redirect_i.taken = redirect_taken;

    assign pred_stream = '{start_addr: pred_start_addr, size: pred_size,
                           target: pred_target, taken: pred_taken};

    assign cache_start_addr = cache_stream.start_addr;
    assign cache_size = cache_stream.size;
    assign cache_target = cache_stream.target;
    assign cache_taken = cache_stream.taken;

    assign update_start_addr = update_stream.start_addr;
    assign update_size = update_stream.size;
    assign update_target = update_stream.target;
    assign update_taken = update_stream.taken;

    // port 0 feeds the icache, port 1 the retire side
    assign store_raddr[0] = rd_ptr;
    assign store_raddr[1] = commit_ptr[idx_w-1:0];

    fsq_store #(
        .depth      (depth),
        .read_ports (2),
        .payload_t  (fetch_stream_t)
    ) stream_store_i (
        .clk   (clk),
        .rst   (rst),
        .we    (store_we),
        .waddr (store_waddr),
        .wdata (store_wdata),
        .raddr (store_raddr),
        .rdata (store_rdata)
    );

    fsq_enqueue #(.depth(depth)) enqueue_i (
        .clk         (clk),
        .rst         (rst),
        .pred_en     (pred_en),
        .pred_stream (pred_stream),
        .redirect    (redirect_i.enq),
        .commit_ptr  (commit_ptr),
        .tail_ptr    (tail_ptr),
        .full        (full),
        .store_we    (store_we),
        .store_waddr (store_waddr),
        .store_wdata (store_wdata)
    );

    fsq_issue #(.depth(depth)) issue_i (
        .clk          (clk),
        .rst          (rst),
        .tail_ptr     (tail_ptr),
        .redirect     (redirect_i.issue),
        .rd_ptr       (rd_ptr),
        .rd_stream    (store_rdata[0]),
        .cache_en     (cache_en),
        .cache_ptr    (cache_ptr),
        .cache_stream (cache_stream),
        .cache_ready  (cache_ready)
    );

    fsq_commit #(.depth(depth)) commit_i (
        .clk         (clk),
        .rst         (rst),
        .commit_num  (commit_num),
        .redirect    (redirect_i.wb),
        .enq_we      (store_we),
        .enq_ptr     (store_waddr),
        .commit_size (store_rdata[1].size),
        .commit_ptr  (commit_ptr),
        .retire      (retire),
        .wb_info     (wb_info)
    );

    fsq_update_gen #(.depth(depth)) update_gen_i (
        .clk            (clk),
        .rst            (rst),
        .retire         (retire),
        .commit_ptr     (commit_ptr),
        .commit_stream  (store_rdata[1]),
        .wb_info        (wb_info),
        .update_en      (update_en),
        .update_ptr     (update_ptr),
        .update_stream  (update_stream),
        .update_mispred (update_mispred)
    );

endmodule

`default_nettype wire

// ==== tb/fsq_tb_pkg.sv ====
`default_nettype none

package fsq_tb_pkg;
    import fsq_pkg::*;

    localparam int depth = 8;
    localparam int ptr_w = $clog2(depth) + 1;

    typedef struct {
        logic [ptr_w-1:0] ptr;
        fetch_stream_t    s;
        wb_info_t         wb;
    } entry_t;

    typedef struct {
        logic [ptr_w-1:0] ptr;
        fetch_stream_t    s;
        logic             mispred;
    } update_t;

    // live streams oldest first, streams not yet sent to the icache
    entry_t  live_q[$];
    entry_t  issue_q[$];
    update_t update_q[$];

    logic [ptr_w-1:0] tail_ptr = '0;
    logic [ptr_w-1:0] commit_ptr = '0;
    int               inst_cnt = 0;
    logic [31:0]      lfsr = 32'h3d823358;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? (s >> 1) ^ 32'h80200003 : s >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic int eff_size(entry_t e);
        return e.wb.mispred ? e.wb.offset : e.s.size;
    endfunction

    // a mispredicted stream reports the backend outcome
    function automatic update_t expected_update(entry_t e);
        update_t u;
        u.ptr = e.ptr;
        u.mispred = e.wb.mispred;
        u.s.start_addr = e.s.start_addr;
        u.s.size = size_w'(eff_size(e));
        u.s.target = e.wb.mispred ? e.wb.target : e.s.target;
        u.s.taken = e.wb.mispred ? e.wb.taken : e.s.taken;
        return u;
    endfunction

    function automatic logic queue_full();
        return tail_ptr == {~commit_ptr[ptr_w-1], commit_ptr[ptr_w-2:0]};
    endfunction

    // instructions the backend may still retire
    function automatic int retire_budget();
        int sum;
        sum = 0;
        foreach (live_q[i]) begin
            sum += eff_size(live_q[i]) + 1;
        end
        return sum - inst_cnt;
    endfunction

    function automatic void add_stream(fetch_stream_t s);
        entry_t e;
        e.ptr = tail_ptr;
        e.s = s;
        e.wb = '0;
        live_q.push_back(e);
        issue_q.push_back(e);
        tail_ptr++;
    endfunction

    // younger streams go, nothing older is issued again
    function automatic void apply_redirect(logic [ptr_w-1:0] ptr, wb_info_t wb);
        while (live_q.size() > 0 && live_q[$].ptr != ptr) begin
            void'(live_q.pop_back());
        end
        live_q[$].wb = wb;
        issue_q.delete();
        tail_ptr = ptr + 1'b1;
    endfunction

    function automatic logic commit_step(int num);
        logic ret;
        ret = live_q.size() > 0 && inst_cnt > eff_size(live_q[0]);
        if (ret) begin
            update_q.push_back(expected_update(live_q[0]));
            inst_cnt -= eff_size(live_q[0]) + 1;
            void'(live_q.pop_front());
            commit_ptr++;
        end
        inst_cnt += num;
        return ret;
    endfunction

endpackage

`default_nettype wire

// ==== tb/fsq_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module fsq_tb;
    import fsq_pkg::*;
    import fsq_tb_pkg::*;

    logic clk, rst, pred_en, pred_taken, full, cache_en, cache_taken, cache_ready;
    logic redirect_en, redirect_taken, update_en, update_taken, update_mispred;
    logic [vaddr_w-1:0] pred_start_addr, pred_target, cache_start_addr, cache_target;
    logic [vaddr_w-1:0] redirect_target, update_start_addr, update_target;
    logic [size_w-1:0] pred_size, cache_size, redirect_offset, update_size;
    logic [ptr_w-1:0] cache_ptr, redirect_ptr, update_ptr, held_ptr;
    logic [commit_num_w-1:0] commit_num;
    logic retired = 1'b0;
    logic hold = 1'b0;
    fetch_stream_t cache_s, update_s, held;

    fsq_top #(.depth(depth)) dut_i (.*);

    assign cache_s = '{cache_start_addr, cache_size, cache_target, cache_taken};
    assign update_s = '{update_start_addr, update_size, update_target, update_taken};

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(200 * 20 * 100);
        $display("run timed out before all tests finished");
        $display("FAIL: see errors above");
        $fatal(1);
    end

    task automatic check(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s is %h, expected %h", name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic match_stream(string p, fetch_stream_t got, fetch_stream_t exp);
        check({p, "_start_addr"}, got.start_addr, exp.start_addr);
        check({p, "_size"}, got.size, exp.size);
        check({p, "_target"}, got.target, exp.target);
        check({p, "_taken"}, got.taken, exp.taken);
    endtask

    // model follows the DUT on the edge that samples the inputs
    always @(posedge clk) begin : compare
        update_t u;
        entry_t  c;
        logic    accept;
        if (!rst) begin
            check("full", full, queue_full());
            check("update_en", update_en, retired);
            if (update_en) begin
                u = update_q.pop_front();
                check("update_ptr", update_ptr, u.ptr);
                check("update_mispred", update_mispred, u.mispred);
                match_stream("update", update_s, u.s);
            end
            if (hold) begin
                check("cache_en", cache_en, 1'b1);
                check("cache_ptr", cache_ptr, held_ptr);
                match_stream("cache", cache_s, held);
            end
            if (cache_en && cache_ready) begin
                check("cache_en", cache_en, issue_q.size() != 0);
                c = issue_q.pop_front();
                check("cache_ptr", cache_ptr, c.ptr);
                match_stream("cache", cache_s, c.s);
            end
            hold = cache_en && !cache_ready && !redirect_en;
            held_ptr = cache_ptr;
            held = cache_s;
            accept = pred_en && !queue_full() && !redirect_en;
            retired = commit_step(commit_num);
            if (redirect_en) begin
                apply_redirect(redirect_ptr,
                               '{1'b1, redirect_offset, redirect_target, redirect_taken});
            end else if (accept) begin
                add_stream('{pred_start_addr, pred_size, pred_target, pred_taken});
            end
        end
    end

    // commit_num never asks for more than the live streams hold
    task automatic drive(logic pred_on, logic ready_on, logic commit_on);
        int n;
        @(negedge clk);
        pred_en = pred_on && rand_bits(1);
        pred_start_addr = rand_bits(32);
        pred_size = size_w'(rand_bits(size_w));
        pred_target = rand_bits(32);
        pred_taken = rand_bits(1);
        cache_ready = ready_on && rand_bits(1);
        n = rand_bits(3) % 5;
        commit_num = commit_on ? commit_num_w'(n < retire_budget() ? n : retire_budget()) : '0;
        redirect_en = 1'b0;
    endtask

    initial begin
        rst = 1'b1;
        {pred_en, pred_start_addr, pred_size, pred_target, pred_taken, cache_ready} = '0;
        {redirect_en, redirect_ptr, redirect_offset, redirect_target, redirect_taken} = '0;
        commit_num = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        check("cache_en", cache_en, 1'b0);
        check("update_en", update_en, 1'b0);
        check("full", full, 1'b0);

        // fill up, then one write that must be dropped
        repeat (depth + 1) begin
            drive(0, 0, 0);
            pred_en = 1'b1;
        end
        check("full", full, 1'b1);
        while (issue_q.size() > 0) begin
            drive(0, 1, 0);
        end

        // mixed traffic, then retire everything
        repeat (150) begin
            drive(1, 1, 1);
        end
        while (live_q.size() > 0 || update_q.size() > 0 || issue_q.size() > 0) begin
            drive(0, 1, 1);
        end

        repeat (5) begin
            drive(0, 1, 0);
            pred_en = 1'b1;
        end
        while (issue_q.size() > 0 || cache_en) begin
            drive(0, 1, 0);
        end
        drive(0, 0, 0);
        redirect_en = 1'b1;
        redirect_ptr = live_q[1].ptr;
        redirect_offset = size_w'(rand_bits(size_w)) & live_q[1].s.size;
        redirect_target = rand_bits(32);
        redirect_taken = rand_bits(1);
        repeat (2) begin
            drive(0, 1, 0);
            pred_en = 1'b1;
        end
        while (live_q.size() > 0 || update_q.size() > 0 || issue_q.size() > 0) begin
            drive(0, 1, 1);
        end
        drive(0, 0, 0);
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/fsq_pkg.sv
logic/fsq_redirect_if.sv
logic/fsq_store.sv
logic/fsq_enqueue.sv
logic/fsq_issue.sv
logic/fsq_commit.sv
logic/fsq_update_gen.sv
logic/fsq_top.sv
tb/fsq_tb_pkg.sv
tb/fsq_tb.sv

// ==== Bender.yml ====
package:
  name: fsq

sources:
  - logic/fsq_pkg.sv
  - logic/fsq_redirect_if.sv
  - logic/fsq_store.sv
  - logic/fsq_enqueue.sv
  - logic/fsq_issue.sv
  - logic/fsq_commit.sv
  - logic/fsq_update_gen.sv
  - logic/fsq_top.sv
  - target: simulation
    files:
      - tb/fsq_tb_pkg.sv
      - tb/fsq_tb.sv
